//--- csr_pkg.sv
/*
  Shared types and constants of the machine-mode CSR unit.
  Machine mode only. No PMP, debug or hpm CSRs, and no upper counter halves.
  mtvec is direct mode only, so its low two bits are always zero.
*/
`default_nettype none

package csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;

  // Counter slots: mcycle and minstret
  localparam int unsigned NUM_CNT      = 2;
  localparam int unsigned CNT_MCYCLE   = 0;
  localparam int unsigned CNT_MINSTRET = 1;

  //////////////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [11:0] CSR_MSTATUS       = 12'h300;
  localparam logic [11:0] CSR_MIE           = 12'h304;
  localparam logic [11:0] CSR_MTVEC         = 12'h305;
  localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;
  localparam logic [11:0] CSR_MSCRATCH      = 12'h340;
  localparam logic [11:0] CSR_MEPC          = 12'h341;
  localparam logic [11:0] CSR_MCAUSE        = 12'h342;
  localparam logic [11:0] CSR_MIP           = 12'h344;
  localparam logic [11:0] CSR_MCYCLE        = 12'hB00;
  localparam logic [11:0] CSR_MINSTRET      = 12'hB02;

  //////////////////////////////////////////////////////////////////////
  // Field positions and reset values
  //////////////////////////////////////////////////////////////////////

  // Only MIE and MPIE exist in mstatus
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // mcountinhibit bits CY and IR
  localparam int unsigned MCOUNTINHIBIT_CY_BIT = 0;
  localparam int unsigned MCOUNTINHIBIT_IR_BIT = 2;

  // Software, timer, external and fast lines 16..31
  localparam logic [XLEN-1:0] IRQ_MASK = 32'hFFFF_0888;
  localparam int unsigned IRQ_MSI     = 3;
  localparam int unsigned IRQ_MTI     = 7;
  localparam int unsigned IRQ_MEI     = 11;
  localparam int unsigned IRQ_FAST_LO = 16;

  localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // CSR slice of the ID/EX stage, access is a one-cycle strobe
  typedef struct packed {
    logic            csr_access;
    csr_op_e         csr_op;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_wdata;
  } id_ex_pipe_t;

  // Controller events, trap_cause[5] flags an interrupt
  typedef struct packed {
    logic            trap_valid;
    logic            mret;
    logic [XLEN-1:0] trap_pc;
    logic [5:0]      trap_cause;
  } ctrl_event_t;

endpackage

`default_nettype wire

//--- csr_counters.sv
/*
  mcycle and minstret, 32 bits each, no upper halves.
  A CSR write replaces the increment of that cycle.
  Inhibit freezes each counter separately but never blocks a write.
*/
`default_nettype none

module csr_counters
  import csr_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                instr_retire,
  input  wire logic [NUM_CNT-1:0]  cnt_we,
  input  wire logic [XLEN-1:0]     cnt_wdata,
  input  wire logic [NUM_CNT-1:0]  cnt_inhibit,
  output logic      [XLEN-1:0]     mcycle,
  output logic      [XLEN-1:0]     minstret
);

  logic [NUM_CNT-1:0][XLEN-1:0] cnt_q;
  logic [NUM_CNT-1:0]           cnt_inc;

  // Increment conditions per slot
  always_comb begin
    cnt_inc               = '0;
    cnt_inc[CNT_MCYCLE]   = !cnt_inhibit[CNT_MCYCLE];
    cnt_inc[CNT_MINSTRET] = instr_retire && !cnt_inhibit[CNT_MINSTRET];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        // Write wins over increment
        if (cnt_we[i]) begin
          cnt_q[i] <= cnt_wdata;
        end else if (cnt_inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign mcycle   = cnt_q[CNT_MCYCLE];
  assign minstret = cnt_q[CNT_MINSTRET];

  // Frozen counter holds across the edge unless software writes it
  for (genvar g = 0; g < NUM_CNT; g++) begin : g_hold_chk
    a_inhibit_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (cnt_inhibit[g] && !cnt_we[g]) |=> $stable(cnt_q[g]));
  end

endmodule

`default_nettype wire

//--- csr_irq_ctrl.sv
/*
  Combinational interrupt request and id selection.
  Fixed priority: fast 31 down to 16, then external, software, timer.
  A mie write takes effect in its own cycle through the bypass.
*/
`default_nettype none

module csr_irq_ctrl
  import csr_pkg::*;
(
  input  wire logic [XLEN-1:0] mip,
  input  wire logic [XLEN-1:0] mie,
  input  wire logic [XLEN-1:0] mie_n,
  input  wire logic            mie_we,
  input  wire logic            mstatus_mie,
  output logic                 irq_req,
  output logic      [4:0]      irq_id
);

  logic [XLEN-1:0] mie_eff;
  logic [XLEN-1:0] pending;

  //////////////////////////////////////////////////////////////////////
  // Enable bypass and masking
  //////////////////////////////////////////////////////////////////////

  // Next mie during its write cycle
  assign mie_eff = mie_we ? mie_n : mie;

  // Only implemented lines can pend
  assign pending = mip & mie_eff & IRQ_MASK;

  // Global enable gates the request, not the id
  assign irq_req = mstatus_mie && (|pending);

  //////////////////////////////////////////////////////////////////////
  // Priority select
  //////////////////////////////////////////////////////////////////////

  // Later assignments win, so lowest priority comes first
  always_comb begin
    irq_id = '0;
    if (pending[IRQ_MTI]) begin
      irq_id = 5'(IRQ_MTI);
    end
    if (pending[IRQ_MSI]) begin
      irq_id = 5'(IRQ_MSI);
    end
    if (pending[IRQ_MEI]) begin
      irq_id = 5'(IRQ_MEI);
    end
    // Fast lines, highest index last so it wins
    for (int i = IRQ_FAST_LO; i < XLEN; i++) begin
      if (pending[i]) begin
        irq_id = 5'(i);
      end
    end
  end

  // Selected id must point at a line that really pends in mip
  always_comb begin
    a_irq_id_pending: assert (!irq_req || mip[irq_id])
      else $error("irq_id %0d not pending in mip", irq_id);
  end

endmodule

`default_nettype wire

//--- csr_regfile.sv
/*
  Machine-mode CSR storage with read, write, set and clear.
  Reads return the old value one cycle after the access and hold until the next one.
  Unknown addresses and any write to mip are illegal, change nothing, read zero.
  Trap entry and mret win over a CSR write in the same cycle.
*/
`default_nettype none

module csr_regfile
  import csr_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire id_ex_pipe_t         id_ex_pipe,
  input  wire ctrl_event_t         ctrl_event,
  input  wire logic [XLEN-1:0]     mip,
  input  wire logic [XLEN-1:0]     mcycle,
  input  wire logic [XLEN-1:0]     minstret,
  output logic      [XLEN-1:0]     csr_rdata,
  output logic                     csr_illegal,
  output logic      [XLEN-1:0]     mtvec,
  output logic      [XLEN-1:0]     mepc,
  output logic      [XLEN-1:0]     mie,
  output logic      [XLEN-1:0]     mie_n,
  output logic                     mie_we,
  output logic                     mstatus_mie,
  output logic      [NUM_CNT-1:0]  cnt_we,
  output logic      [XLEN-1:0]     cnt_wdata,
  output logic      [NUM_CNT-1:0]  cnt_inhibit
);

  // Stored CSR state
  logic               mie_bit_q;
  logic               mpie_bit_q;
  logic [XLEN-1:0]    mie_q;
  logic [XLEN-1:0]    mtvec_q;
  logic [XLEN-1:0]    mscratch_q;
  logic [XLEN-1:0]    mepc_q;
  logic [XLEN-1:0]    mcause_q;
  logic [NUM_CNT-1:0] inhibit_q;

  // Access decode
  logic [11:0]        addr;
  logic               addr_ok;
  logic               csr_wr;
  logic               illegal;
  logic               csr_we;
  logic [XLEN-1:0]    old_val;
  logic [XLEN-1:0]    wval;

  //////////////////////////////////////////////////////////////////////
  // Decode and old value
  //////////////////////////////////////////////////////////////////////

  assign addr = id_ex_pipe.csr_addr;

  always_comb begin
    addr_ok = 1'b1;
    old_val = '0;
    case (addr)
      CSR_MSTATUS: begin
        old_val[MSTATUS_MIE_BIT]  = mie_bit_q;
        old_val[MSTATUS_MPIE_BIT] = mpie_bit_q;
      end
      CSR_MIE:      old_val = mie_q;
      CSR_MTVEC:    old_val = mtvec_q;
      CSR_MSCRATCH: old_val = mscratch_q;
      CSR_MEPC:     old_val = mepc_q;
      CSR_MCAUSE:   old_val = mcause_q;
      CSR_MIP:      old_val = mip;
      CSR_MCYCLE:   old_val = mcycle;
      CSR_MINSTRET: old_val = minstret;
      CSR_MCOUNTINHIBIT: begin
        old_val[MCOUNTINHIBIT_CY_BIT] = inhibit_q[CNT_MCYCLE];
        old_val[MCOUNTINHIBIT_IR_BIT] = inhibit_q[CNT_MINSTRET];
      end
      default:      addr_ok = 1'b0;
    endcase
  end

  // Set and clear count as writes too
  assign csr_wr  = id_ex_pipe.csr_access && (id_ex_pipe.csr_op != CSR_OP_READ);
  // mip is read-only from software
  assign illegal = id_ex_pipe.csr_access && (!addr_ok || (addr == CSR_MIP && csr_wr));
  assign csr_we  = csr_wr && !illegal;

  // Read-modify-write result before field masking
  always_comb begin
    case (id_ex_pipe.csr_op)
      CSR_OP_WRITE: wval = id_ex_pipe.csr_wdata;
      CSR_OP_SET:   wval = old_val | id_ex_pipe.csr_wdata;
      CSR_OP_CLEAR: wval = old_val & ~id_ex_pipe.csr_wdata;
      default:      wval = old_val;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Side ports to counters and interrupt control
  //////////////////////////////////////////////////////////////////////

  assign mie_n  = wval & IRQ_MASK;
  assign mie_we = csr_we && (addr == CSR_MIE);

  always_comb begin
    cnt_we               = '0;
    cnt_we[CNT_MCYCLE]   = csr_we && (addr == CSR_MCYCLE);
    cnt_we[CNT_MINSTRET] = csr_we && (addr == CSR_MINSTRET);
  end

  assign cnt_wdata   = wval;
  assign cnt_inhibit = inhibit_q;
  assign mstatus_mie = mie_bit_q;
  assign mie         = mie_q;
  assign mtvec       = mtvec_q;
  assign mepc        = mepc_q;

  //////////////////////////////////////////////////////////////////////
  // State update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_bit_q   <= 1'b0;
      mpie_bit_q  <= 1'b0;
      mie_q       <= '0;
      mtvec_q     <= MTVEC_RESET;
      mscratch_q  <= '0;
      mepc_q      <= '0;
      mcause_q    <= '0;
      inhibit_q   <= '0;
      csr_rdata   <= '0;
      csr_illegal <= 1'b0;
    end else begin
      // mstatus priority is trap, then mret, then software
      if (ctrl_event.trap_valid) begin
        mpie_bit_q <= mie_bit_q;
        mie_bit_q  <= 1'b0;
      end else if (ctrl_event.mret) begin
        mie_bit_q  <= mpie_bit_q;
        mpie_bit_q <= 1'b1;
      end else if (csr_we && addr == CSR_MSTATUS) begin
        mie_bit_q  <= wval[MSTATUS_MIE_BIT];
        mpie_bit_q <= wval[MSTATUS_MPIE_BIT];
      end

      // Trap entry owns mepc and mcause
      if (ctrl_event.trap_valid) begin
        mepc_q   <= ctrl_event.trap_pc;
        mcause_q <= {ctrl_event.trap_cause[5], 26'b0, ctrl_event.trap_cause[4:0]};
      end else begin
        if (csr_we && addr == CSR_MEPC) begin
          mepc_q <= wval;
        end
        if (csr_we && addr == CSR_MCAUSE) begin
          mcause_q <= wval;
        end
      end

      if (mie_we) begin
        mie_q <= mie_n;
      end
      // Direct mode only
      if (csr_we && addr == CSR_MTVEC) begin
        mtvec_q <= {wval[XLEN-1:2], 2'b00};
      end
      if (csr_we && addr == CSR_MSCRATCH) begin
        mscratch_q <= wval;
      end
      if (csr_we && addr == CSR_MCOUNTINHIBIT) begin
        inhibit_q[CNT_MCYCLE]   <= wval[MCOUNTINHIBIT_CY_BIT];
        inhibit_q[CNT_MINSTRET] <= wval[MCOUNTINHIBIT_IR_BIT];
      end

      // Read result captured with the old value and held until next access
      if (id_ex_pipe.csr_access) begin
        csr_rdata   <= illegal ? '0 : old_val;
        csr_illegal <= illegal;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Read result holds through idle cycles
  a_stable_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ex_pipe.csr_access |=> ($stable(csr_rdata) && $stable(csr_illegal)));

  // Bypass value keeps every enabled line on a set and adds none on a clear
  a_mie_bypass: assert property (@(posedge clk) disable iff (!rst_n)
    mie_we |-> ((id_ex_pipe.csr_op != CSR_OP_SET || (mie_q & ~mie_n) == '0) &&
                (id_ex_pipe.csr_op != CSR_OP_CLEAR || (mie_n & ~mie_q) == '0)));

  a_illegal_needs_access: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(csr_illegal) |-> $past(id_ex_pipe.csr_access));

endmodule

`default_nettype wire

//--- csr_unit.sv
/*
  Top level of the machine-mode CSR unit.
  irq lines are level sensitive and sampled into mip on every edge,
  so a line change reaches irq_req one cycle later.
*/
`default_nettype none

module csr_unit
  import csr_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire id_ex_pipe_t     id_ex_pipe,
  input  wire ctrl_event_t     ctrl_event,
  input  wire logic [XLEN-1:0] irq,
  input  wire logic            instr_retire,
  output logic      [XLEN-1:0] csr_rdata,
  output logic                 csr_illegal,
  output logic      [XLEN-1:0] mtvec,
  output logic      [XLEN-1:0] mepc,
  output logic                 irq_req,
  output logic      [4:0]      irq_id
);

  logic [XLEN-1:0]    mip;
  logic [XLEN-1:0]    mcycle;
  logic [XLEN-1:0]    minstret;
  logic [XLEN-1:0]    mie;
  logic [XLEN-1:0]    mie_n;
  logic               mie_we;
  logic               mstatus_mie;
  logic [NUM_CNT-1:0] cnt_we;
  logic [XLEN-1:0]    cnt_wdata;
  logic [NUM_CNT-1:0] cnt_inhibit;

  // Pending register, unimplemented lines read zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mip <= '0;
    end else begin
      mip <= irq & IRQ_MASK;
    end
  end

  csr_regfile regfile_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_ex_pipe  (id_ex_pipe),
    .ctrl_event  (ctrl_event),
    .mip         (mip),
    .mcycle      (mcycle),
    .minstret    (minstret),
    .csr_rdata   (csr_rdata),
    .csr_illegal (csr_illegal),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mie         (mie),
    .mie_n       (mie_n),
    .mie_we      (mie_we),
    .mstatus_mie (mstatus_mie),
    .cnt_we      (cnt_we),
    .cnt_wdata   (cnt_wdata),
    .cnt_inhibit (cnt_inhibit)
  );

  csr_counters counters_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_retire (instr_retire),
    .cnt_we       (cnt_we),
    .cnt_wdata    (cnt_wdata),
    .cnt_inhibit  (cnt_inhibit),
    .mcycle       (mcycle),
    .minstret     (minstret)
  );

  csr_irq_ctrl irq_ctrl_i (
    .mip         (mip),
    .mie         (mie),
    .mie_n       (mie_n),
    .mie_we      (mie_we),
    .mstatus_mie (mstatus_mie),
    .irq_req     (irq_req),
    .irq_id      (irq_id)
  );

endmodule

`default_nettype wire

//--- tb_csr_unit.sv
/*
  Testbench for the machine-mode CSR unit.
  A shadow model of every CSR advances on each falling edge and is compared
  with the DUT before it steps, so reads, holds, counters and irq_req are
  checked on every cycle. irq_id is only checked while a request is expected.
  Random stimulus uses a fixed seed.
*/
`default_nettype none

module tb_csr_unit
  import csr_pkg::*;
();

  localparam int RAND_CYCLES    = 300;
  // Reset, rw, illegal, trap, random irq, counters
  localparam int TEST_CYCLES    = 10 + 110 + 70 + 40 + RAND_CYCLES + 10 + 100;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

  // Shadow of the architectural state plus the held read result
  typedef struct packed {
    logic               mie_bit;
    logic               mpie_bit;
    logic [XLEN-1:0]    mie;
    logic [XLEN-1:0]    mtvec;
    logic [XLEN-1:0]    mscratch;
    logic [XLEN-1:0]    mepc;
    logic [XLEN-1:0]    mcause;
    logic [XLEN-1:0]    mcycle;
    logic [XLEN-1:0]    minstret;
    logic [XLEN-1:0]    mip;
    logic [NUM_CNT-1:0] inhibit;
    logic [XLEN-1:0]    rdata;
    logic               illegal;
  } model_t;

  logic            clk;
  logic            rst_n;
  id_ex_pipe_t     id_ex_pipe;
  ctrl_event_t     ctrl_event;
  logic [XLEN-1:0] irq;
  logic            instr_retire;
  logic [XLEN-1:0] csr_rdata;
  logic            csr_illegal;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic            irq_req;
  logic [4:0]      irq_id;

  model_t          model;
  logic [XLEN-1:0] mie_eff;
  logic [5:0]      exp_sel;
  logic            exp_req;
  integer          seed = 32'hafd3;
  int              error_count = 0;
  int              check_count = 0;
  int              cycle_count = 0;
  string           test_name = "reset";

  csr_unit dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex_pipe   (id_ex_pipe),
    .ctrl_event   (ctrl_event),
    .irq          (irq),
    .instr_retire (instr_retire),
    .csr_rdata    (csr_rdata),
    .csr_illegal  (csr_illegal),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .irq_req      (irq_req),
    .irq_id       (irq_id)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] rmw_value(input csr_op_e op, input logic [XLEN-1:0] old,
                                                input logic [XLEN-1:0] wdata);
    case (op)
      CSR_OP_WRITE: return wdata;
      CSR_OP_SET:   return old | wdata;
      CSR_OP_CLEAR: return old & ~wdata;
      default:      return old;
    endcase
  endfunction

  function automatic logic known_addr(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
      CSR_MIP, CSR_MCYCLE, CSR_MINSTRET, CSR_MCOUNTINHIBIT: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] read_value(input model_t m, input logic [11:0] addr);
    logic [XLEN-1:0] v;
    v = '0;
    case (addr)
      CSR_MSTATUS: begin
        v[MSTATUS_MIE_BIT]  = m.mie_bit;
        v[MSTATUS_MPIE_BIT] = m.mpie_bit;
      end
      CSR_MIE:      v = m.mie;
      CSR_MTVEC:    v = m.mtvec;
      CSR_MSCRATCH: v = m.mscratch;
      CSR_MEPC:     v = m.mepc;
      CSR_MCAUSE:   v = m.mcause;
      CSR_MIP:      v = m.mip;
      CSR_MCYCLE:   v = m.mcycle;
      CSR_MINSTRET: v = m.minstret;
      CSR_MCOUNTINHIBIT: begin
        v[MCOUNTINHIBIT_CY_BIT] = m.inhibit[CNT_MCYCLE];
        v[MCOUNTINHIBIT_IR_BIT] = m.inhibit[CNT_MINSTRET];
      end
      default:      v = '0;
    endcase
    return v;
  endfunction

  // Bit 5 flags a hit and the low bits give the line
  function automatic logic [5:0] select_irq(input logic [XLEN-1:0] pend);
    logic [XLEN-1:0] live;
    live = pend & IRQ_MASK;
    // Fast lines first and the top one wins
    for (int i = 31; i >= 16; i--) begin
      if (live[i]) begin
        return {1'b1, 5'(i)};
      end
    end
    if (live[11]) begin
      return {1'b1, 5'd11};
    end
    if (live[3]) begin
      return {1'b1, 5'd3};
    end
    if (live[7]) begin
      return {1'b1, 5'd7};
    end
    return 6'd0;
  endfunction

  // State after the next rising edge
  function automatic model_t next_model(input model_t m, input id_ex_pipe_t p,
                                        input ctrl_event_t e, input logic [XLEN-1:0] irq_in,
                                        input logic retire);
    model_t          n;
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] wv;
    logic            wr;
    logic            ill;
    logic            we;
    n   = m;
    old = read_value(m, p.csr_addr);
    wv  = rmw_value(p.csr_op, old, p.csr_wdata);
    wr  = p.csr_access && (p.csr_op != CSR_OP_READ);
    ill = p.csr_access && (!known_addr(p.csr_addr) || (wr && p.csr_addr == CSR_MIP));
    we  = wr && !ill;
    // Read before write and illegal reads zero
    if (p.csr_access) begin
      n.rdata   = ill ? '0 : old;
      n.illegal = ill;
    end
    if (e.trap_valid) begin
      n.mpie_bit = m.mie_bit;
      n.mie_bit  = 1'b0;
      n.mepc     = e.trap_pc;
      n.mcause   = {e.trap_cause[5], 26'b0, e.trap_cause[4:0]};
    end else if (e.mret) begin
      n.mie_bit  = m.mpie_bit;
      n.mpie_bit = 1'b1;
    end
    if (we && p.csr_addr == CSR_MSTATUS && !e.trap_valid && !e.mret) begin
      n.mie_bit  = wv[MSTATUS_MIE_BIT];
      n.mpie_bit = wv[MSTATUS_MPIE_BIT];
    end
    // Trap owns mepc and mcause
    if (we && !e.trap_valid && p.csr_addr == CSR_MEPC) begin
      n.mepc = wv;
    end
    if (we && !e.trap_valid && p.csr_addr == CSR_MCAUSE) begin
      n.mcause = wv;
    end
    if (we && p.csr_addr == CSR_MIE) begin
      n.mie = wv & IRQ_MASK;
    end
    if (we && p.csr_addr == CSR_MTVEC) begin
      n.mtvec = wv & 32'hFFFF_FFFC;
    end
    if (we && p.csr_addr == CSR_MSCRATCH) begin
      n.mscratch = wv;
    end
    if (we && p.csr_addr == CSR_MCOUNTINHIBIT) begin
      n.inhibit[CNT_MCYCLE]   = wv[MCOUNTINHIBIT_CY_BIT];
      n.inhibit[CNT_MINSTRET] = wv[MCOUNTINHIBIT_IR_BIT];
    end
    // Counter write replaces the increment
    if (we && p.csr_addr == CSR_MCYCLE) begin
      n.mcycle = wv;
    end else if (!m.inhibit[CNT_MCYCLE]) begin
      n.mcycle = m.mcycle + 32'd1;
    end
    if (we && p.csr_addr == CSR_MINSTRET) begin
      n.minstret = wv;
    end else if (retire && !m.inhibit[CNT_MINSTRET]) begin
      n.minstret = m.minstret + 32'd1;
    end
    n.mip = irq_in & IRQ_MASK;
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Comparison on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string what, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      model       = '0;
      model.mtvec = MTVEC_RESET;
    end else begin
      compare("csr_rdata", model.rdata, csr_rdata);
      compare("csr_illegal", 32'(model.illegal), 32'(csr_illegal));
      compare("mtvec", model.mtvec, mtvec);
      compare("mepc", model.mepc, mepc);
      // mie write counts in its own cycle
      if (id_ex_pipe.csr_access && id_ex_pipe.csr_op != CSR_OP_READ &&
          id_ex_pipe.csr_addr == CSR_MIE) begin
        mie_eff = rmw_value(id_ex_pipe.csr_op, model.mie, id_ex_pipe.csr_wdata) & IRQ_MASK;
      end else begin
        mie_eff = model.mie;
      end
      exp_sel = select_irq(model.mip & mie_eff);
      exp_req = model.mie_bit && exp_sel[5];
      compare("irq_req", 32'(exp_req), 32'(irq_req));
      if (exp_req) begin
        compare("irq_id", 32'(exp_sel[4:0]), 32'(irq_id));
      end
      model = next_model(model, id_ex_pipe, ctrl_event, irq, instr_retire);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  function automatic id_ex_pipe_t make_access(input csr_op_e op, input logic [11:0] addr,
                                              input logic [XLEN-1:0] wdata);
    id_ex_pipe_t p;
    p.csr_access = 1'b1;
    p.csr_op     = op;
    p.csr_addr   = addr;
    p.csr_wdata  = wdata;
    return p;
  endfunction

  function automatic ctrl_event_t make_event(input logic trap, input logic mret,
                                             input logic [XLEN-1:0] pc, input logic [5:0] cause);
    ctrl_event_t e;
    e.trap_valid = trap;
    e.mret       = mret;
    e.trap_pc    = pc;
    e.trap_cause = cause;
    return e;
  endfunction

  task automatic drive_cycle(input id_ex_pipe_t p, input ctrl_event_t e);
    @(posedge clk);
    id_ex_pipe <= p;
    ctrl_event <= e;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle('0, '0);
  endtask

  // One access strobe, then one quiet cycle
  task automatic issue_access(input csr_op_e op, input logic [11:0] addr,
                              input logic [XLEN-1:0] wdata);
    drive_cycle(make_access(op, addr, wdata), '0);
    drive_cycle('0, '0);
  endtask

  task automatic rw_sequence(input logic [11:0] addr);
    logic [XLEN-1:0] r;
    r = $random(seed);
    issue_access(CSR_OP_WRITE, addr, r);
    issue_access(CSR_OP_READ, addr, '0);
    r = $random(seed);
    issue_access(CSR_OP_SET, addr, r);
    r = $random(seed);
    issue_access(CSR_OP_CLEAR, addr, r);
    issue_access(CSR_OP_READ, addr, '0);
    idle_cycles(3);
  endtask

  initial begin
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] w;
    logic [XLEN-1:0] q;
    id_ex_pipe_t     p;
    rst_n        = 1'b0;
    id_ex_pipe   = '0;
    ctrl_event   = '0;
    irq          = '0;
    instr_retire = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycles(2);

    // Read, write, set, clear on each writable CSR
    test_name = "csr_rw";
    rw_sequence(CSR_MSTATUS);
    rw_sequence(CSR_MIE);
    rw_sequence(CSR_MTVEC);
    rw_sequence(CSR_MSCRATCH);
    rw_sequence(CSR_MEPC);
    rw_sequence(CSR_MCAUSE);
    rw_sequence(CSR_MCOUNTINHIBIT);
    issue_access(CSR_OP_READ, CSR_MIP, '0);
    issue_access(CSR_OP_READ, CSR_MCYCLE, '0);
    issue_access(CSR_OP_READ, CSR_MINSTRET, '0);

    // Unknown addresses and mip writes
    test_name = "illegal";
    issue_access(CSR_OP_READ, 12'h301, '0);
    issue_access(CSR_OP_WRITE, 12'h301, 32'hFFFF_FFFF);
    issue_access(CSR_OP_READ, 12'hF14, '0);
    issue_access(CSR_OP_WRITE, 12'hB80, 32'h1234_5678);
    issue_access(CSR_OP_SET, 12'hC00, 32'h0000_00FF);
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      w = $random(seed);
      issue_access(csr_op_e'(r[13:12]), r[11:0], w);
    end
    issue_access(CSR_OP_WRITE, CSR_MIP, 32'hFFFF_FFFF);
    issue_access(CSR_OP_SET, CSR_MIP, 32'h0000_0888);
    issue_access(CSR_OP_CLEAR, CSR_MIP, 32'hFFFF_FFFF);
    issue_access(CSR_OP_READ, CSR_MSCRATCH, '0);
    issue_access(CSR_OP_READ, CSR_MCAUSE, '0);
    issue_access(CSR_OP_READ, CSR_MIE, '0);
    issue_access(CSR_OP_READ, CSR_MSTATUS, '0);
    idle_cycles(3);

    // Trap entry and mret
    test_name = "trap";
    issue_access(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008);
    drive_cycle('0, make_event(1'b1, 1'b0, 32'h8000_0124, 6'h2B));
    drive_cycle('0, '0);
    issue_access(CSR_OP_READ, CSR_MEPC, '0);
    issue_access(CSR_OP_READ, CSR_MCAUSE, '0);
    issue_access(CSR_OP_READ, CSR_MSTATUS, '0);
    drive_cycle('0, make_event(1'b0, 1'b1, '0, '0));
    drive_cycle('0, '0);
    issue_access(CSR_OP_READ, CSR_MSTATUS, '0);
    // MIE low before the trap, so MPIE and the restored MIE come out low
    issue_access(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0080);
    // Same-cycle software writes lose to the event
    drive_cycle(make_access(CSR_OP_WRITE, CSR_MEPC, 32'hDEAD_BEE0),
                make_event(1'b1, 1'b0, 32'h0000_0400, 6'h02));
    drive_cycle('0, '0);
    issue_access(CSR_OP_READ, CSR_MEPC, '0);
    issue_access(CSR_OP_READ, CSR_MCAUSE, '0);
    drive_cycle(make_access(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0088),
                make_event(1'b0, 1'b1, '0, '0));
    drive_cycle('0, '0);
    issue_access(CSR_OP_READ, CSR_MSTATUS, '0);
    idle_cycles(3);

    // Random irq lines against mie and mstatus writes
    test_name = "irq_random";
    issue_access(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008);
    for (int k = 0; k < RAND_CYCLES; k++) begin
      r = $random(seed);
      w = $random(seed);
      q = $random(seed) & $random(seed);
      p = '0;
      if (r[2:0] < 3'd2) begin
        p = make_access(csr_op_e'(r[4:3]), CSR_MIE, w);
      end else if (r[2:0] == 3'd2) begin
        p = make_access(CSR_OP_WRITE, CSR_MSTATUS, w & 32'h0000_0088);
      end
      // Half the time only the low lines so 3, 7 and 11 get picked
      if (r[6]) begin
        q = q & 32'h0000_0888;
      end
      @(posedge clk);
      id_ex_pipe <= p;
      irq        <= q;
    end
    @(posedge clk);
    id_ex_pipe <= '0;
    irq        <= '0;
    idle_cycles(3);

    // Counters, writes and inhibit
    test_name = "counters";
    issue_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0);
    for (int k = 0; k < 20; k++) begin
      r = $random(seed);
      @(posedge clk);
      instr_retire <= r[0];
    end
    @(posedge clk);
    instr_retire <= 1'b0;
    issue_access(CSR_OP_READ, CSR_MINSTRET, '0);
    issue_access(CSR_OP_READ, CSR_MCYCLE, '0);
    issue_access(CSR_OP_WRITE, CSR_MCYCLE, 32'h0000_1000);
    issue_access(CSR_OP_READ, CSR_MCYCLE, '0);
    issue_access(CSR_OP_WRITE, CSR_MINSTRET, 32'hFFFF_FFFE);
    // Wraps past zero
    repeat (4) begin
      @(posedge clk);
      instr_retire <= 1'b1;
    end
    @(posedge clk);
    instr_retire <= 1'b0;
    issue_access(CSR_OP_READ, CSR_MINSTRET, '0);
    issue_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0000_0005);
    idle_cycles(10);
    issue_access(CSR_OP_READ, CSR_MCYCLE, '0);
    repeat (5) begin
      @(posedge clk);
      instr_retire <= 1'b1;
    end
    @(posedge clk);
    instr_retire <= 1'b0;
    issue_access(CSR_OP_READ, CSR_MCYCLE, '0);
    issue_access(CSR_OP_READ, CSR_MINSTRET, '0);
    // Write still lands while frozen
    issue_access(CSR_OP_WRITE, CSR_MCYCLE, 32'h0000_00A0);
    issue_access(CSR_OP_READ, CSR_MCYCLE, '0);
    issue_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0);
    idle_cycles(4);
    issue_access(CSR_OP_READ, CSR_MCYCLE, '0);
    idle_cycles(3);

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
csr_pkg.sv
csr_counters.sv
csr_irq_ctrl.sv
csr_regfile.sv
csr_unit.sv
tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_csr_unit -f flist.f -o sim_csr_unit
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_csr_unit > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
